/* list.f */
+incdir+include
src/motor_pkg.sv
src/reg_bus_arbiter.sv
src/rt_block_writer.sv
src/dac_cmd_regs.sv
src/safety_monitor.sv
src/board_status_regs.sv
src/motor_board_top.sv
dv/tb_clock_gen.sv
dv/motor_board_tb.sv

/* Makefile */
# Verilator build and run of the motor board testbench
VERILATOR ?= verilator
TOP       ?= motor_board_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '=== FAIL ===' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exit status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/motor_board_tb.sv */
// assumes host writes never overlap an rt write and reads adc data only after a strobe
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module motor_board_tb import motor_pkg::*; ();

    logic               sysclk;
    logic               rst_n;
    logic [3:0]         board_id;
    reg_wr_t            eth_wr;
    reg_wr_t            fw_wr;
    rt_wr_t             rt_in;
    logic               eth_read_en;
    reg_addr_t          eth_raddr;
    reg_addr_t          fw_raddr;
    cur_vec_t           cur_fb;
    logic               cur_ready;
    logic [`DATA_W-1:0] reg_rdata;
    logic               pwr_enable;
    axis_vec_t          amp_enable;

    // --------------------
    // cycle model state
    cur_vec_t           m_cmd;
    cur_vec_t           m_fb;
    logic               m_pwr;
    axis_vec_t          m_amp;          // commanded enables
    axis_vec_t          m_dis;          // safety latches
    axis_vec_t          m_amp_eff;
    int                 m_cnt [`NUM_AXES];
    logic [`DATA_W-1:0] m_rdata;        // expected reg_rdata
    logic               m_rt_wen;       // rt write one clock behind
    logic [2:0]         m_rt_idx;
    logic [`DATA_W-1:0] m_rt_data;

    logic [31:0]        rng;
    int                 errors = 0;
    int                 errors_before = 0;
    int                 tests_run = 0;
    int                 tests_bad = 0;

    tb_clock_gen i_clk (.sysclk(sysclk), .rst_n(rst_n));

    motor_board_top i_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic reg_addr_t main_addr(input logic [3:0] chan, input logic [3:0] off);
        return '{space: `ADDR_MAIN, rsvd: 4'h0, chan: chan, offset: off};
    endfunction

    function automatic reg_addr_t rt_target(input logic [2:0] idx);
        if (idx == 3'd0)
            return main_addr(4'h0, `OFF_STATUS);
        return main_addr({1'b0, idx}, `OFF_DAC_CTRL);   // channel equals index
    endfunction

    function automatic logic [`DATA_W-1:0] status_cmd(input logic pmask, input logic pval,
                                                      input axis_vec_t amask,
                                                      input axis_vec_t aval);
        logic [`DATA_W-1:0] d;
        d = '0;
        d[`ST_PWR_MASK] = pmask;
        d[`ST_PWR_VAL]  = pval;
        d[`ST_AMP_MASK] = amask;
        d[`ST_AMP_VAL]  = aval;
        return d;
    endfunction

    // expected read word for an address, from the model state
    function automatic logic [`DATA_W-1:0] model_read(input reg_addr_t a);
        logic [`DATA_W-1:0] v;
        v = '0;
        if (a.space == `ADDR_MAIN && a.rsvd == 4'h0) begin
            if (a.chan == 4'h0 && a.offset == `OFF_STATUS) begin
                v[`ST_BOARD_ID]   = board_id;
                v[`ST_PWR_EN]     = m_pwr;
                v[`ST_SAFETY_DIS] = m_dis;
                v[`ST_AMP_EN]     = m_amp_eff;
            end else if (a.chan >= 4'h1 && a.chan <= 4'(`NUM_AXES)) begin
                if (a.offset == `OFF_ADC_DATA)
                    v[`CUR_W-1:0] = m_fb[2'(a.chan - 4'h1)];
                else if (a.offset == `OFF_DAC_CTRL)
                    v[`CUR_W-1:0] = m_cmd[2'(a.chan - 4'h1)];
            end
        end
        return v;
    endfunction

    function automatic void report_value(input string name, input logic [31:0] got,
                                         input logic [31:0] exp);
        $display("CHECK FAILED %s got %h exp %h at %0t", name, got, exp, $time);
        errors++;
    endfunction

    assign m_amp_eff = m_amp & {`NUM_AXES{m_pwr}} & ~m_dis;    // power and latch gate

    // --------------------
    // scoreboard model
    always @(posedge sysclk or negedge rst_n) begin : model
        reg_wr_t   w;
        axis_vec_t clr;
        logic      over;
        if (!rst_n) begin
            m_cmd    <= '0;
            m_pwr    <= 1'b0;
            m_amp    <= '0;
            m_dis    <= '0;
            m_rdata  <= '0;
            m_rt_wen <= 1'b0;
            for (int a = 0; a < `NUM_AXES; a++)
                m_cnt[a] <= 0;
        end else begin
            m_rdata   <= model_read(eth_read_en ? eth_raddr : fw_raddr);
            m_rt_wen  <= rt_in.wen && (rt_in.idx < 3'd5);     // 5-7 dropped
            m_rt_idx  <= rt_in.idx;
            m_rt_data <= rt_in.wdata;
            w = '0;
            if (m_rt_wen)
                w = '{wen: 1'b1, waddr: rt_target(m_rt_idx), wdata: m_rt_data};
            else if (eth_wr.wen)
                w = eth_wr;
            else if (fw_wr.wen)
                w = fw_wr;
            clr = '0;
            if (w.wen && w.waddr == main_addr(4'h0, `OFF_STATUS)) begin
                if (w.wdata[`ST_PWR_MASK])
                    m_pwr <= w.wdata[`ST_PWR_VAL];
                m_amp <= (m_amp & ~w.wdata[`ST_AMP_MASK])
                       | (w.wdata[`ST_AMP_VAL] & w.wdata[`ST_AMP_MASK]);
                clr = w.wdata[`ST_AMP_MASK] & w.wdata[`ST_AMP_VAL];
                if (w.wdata[`ST_PWR_MASK] && w.wdata[`ST_PWR_VAL])
                    clr = '1;   // power on clears every latch
            end
            if (w.wen && w.waddr.space == `ADDR_MAIN && w.waddr.rsvd == 4'h0
                    && w.waddr.offset == `OFF_DAC_CTRL
                    && w.waddr.chan >= 4'h1 && w.waddr.chan <= 4'(`NUM_AXES))
                m_cmd[2'(w.waddr.chan - 4'h1)] <= w.wdata[`CUR_W-1:0];
            if (cur_ready)
                m_fb <= cur_fb;
            for (int a = 0; a < `NUM_AXES; a++) begin
                over = {1'b0, cur_fb[a]} > 17'(m_cmd[a]) * 17'd2;
                if (clr[a]) begin
                    m_cnt[a] <= 0;
                    m_dis[a] <= 1'b0;
                end else if (cur_ready && over) begin
                    if (m_cnt[a] < `SAFETY_COUNT)
                        m_cnt[a] <= m_cnt[a] + 1;
                    if (m_cnt[a] + 1 >= `SAFETY_COUNT)
                        m_dis[a] <= 1'b1;
                end else if (cur_ready) begin
                    m_cnt[a] <= 0;  // compliant sample
                end
            end
        end
    end

    // --------------------
    // checks
    a_rdata: assert property (@(posedge sysclk) disable iff (!rst_n) reg_rdata == m_rdata)
        else report_value("reg_rdata", $sampled(reg_rdata), $sampled(m_rdata));
    a_pwr: assert property (@(posedge sysclk) disable iff (!rst_n) pwr_enable == m_pwr)
        else report_value("pwr_enable", 32'($sampled(pwr_enable)), 32'($sampled(m_pwr)));
    a_amp: assert property (@(posedge sysclk) disable iff (!rst_n) amp_enable == m_amp_eff)
        else report_value("amp_enable", 32'($sampled(amp_enable)), 32'($sampled(m_amp_eff)));

    task automatic tick();
        @(posedge sysclk);
        #1;     // drive after the edge
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge sysclk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            abort_on_timeout("reset release");
        end else begin
            #1;
        end
    endtask

    task automatic wait_amp_low(input logic [1:0] ax);
        int n;
        n = 0;
        while (amp_enable[ax] && n < 8) begin
            tick();
            n++;
        end
        if (amp_enable[ax])
            abort_on_timeout("amp_enable to drop after over-current samples");
    endtask

    task automatic host_write(input bit use_eth, input reg_addr_t a, input logic [31:0] d);
        if (use_eth)
            eth_wr = '{wen: 1'b1, waddr: a, wdata: d};
        else
            fw_wr = '{wen: 1'b1, waddr: a, wdata: d};
        tick();
        eth_wr.wen = 1'b0;
        fw_wr.wen  = 1'b0;
    endtask

    task automatic read_reg(input bit use_eth, input reg_addr_t a);
        eth_read_en = use_eth;
        if (use_eth)
            eth_raddr = a;
        else
            fw_raddr = a;
        tick();
        tick();     // reg_rdata one edge behind
    endtask

    task automatic rt_quadlet(input logic [2:0] idx, input logic [31:0] d);
        rt_in = '{wen: 1'b1, idx: idx, wdata: d};
        tick();
        rt_in.wen = 1'b0;
        tick();     // bus write lands here
    endtask

    task automatic adc_sample(input logic [1:0] ax, input logic [`CUR_W-1:0] fb);
        cur_fb[ax] = fb;
        cur_ready  = 1'b1;
        tick();
        cur_ready  = 1'b0;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // --------------------
    // stimulus
    initial begin : stim
        board_id    = 4'ha;
        eth_wr      = '0;
        fw_wr       = '0;
        rt_in       = '0;
        eth_read_en = 1'b0;
        eth_raddr   = '0;
        fw_raddr    = '0;
        cur_fb      = '0;
        cur_ready   = 1'b0;
        rng         = 32'h210f9928;
        wait_reset_release();

        read_reg(1'b0, main_addr(4'h0, `OFF_STATUS));
        read_reg(1'b1, main_addr(4'h0, `OFF_STATUS));
        close_test("reset values");

        for (int c = 1; c <= `NUM_AXES; c++) begin
            rng = xorshift(rng);
            host_write(c[0], main_addr(4'(c), `OFF_DAC_CTRL), rng);
            read_reg(1'b1, main_addr(4'(c), `OFF_DAC_CTRL));
            read_reg(1'b0, main_addr(4'(c), `OFF_DAC_CTRL));
        end
        read_reg(1'b1, main_addr(4'h5, `OFF_DAC_CTRL));     // no such axis
        read_reg(1'b0, main_addr(4'h0, 4'h3));
        read_reg(1'b1, '{space: 4'h1, rsvd: 4'h0, chan: 4'h1, offset: `OFF_DAC_CTRL});
        close_test("dac readback");

        host_write(1'b1, main_addr(4'h0, `OFF_STATUS), status_cmd(1'b1, 1'b1, 4'hf, 4'h5));
        read_reg(1'b0, main_addr(4'h0, `OFF_STATUS));
        host_write(1'b0, main_addr(4'h0, `OFF_STATUS), status_cmd(1'b0, 1'b0, 4'h2, 4'h2));
        read_reg(1'b0, main_addr(4'h0, `OFF_STATUS));
        host_write(1'b1, main_addr(4'h0, `OFF_STATUS), status_cmd(1'b1, 1'b0, 4'h0, 4'h0));
        read_reg(1'b1, main_addr(4'h0, `OFF_STATUS));
        close_test("status enables");

        rt_quadlet(3'd0, status_cmd(1'b1, 1'b1, 4'hf, 4'hf));
        rt_quadlet(3'd3, 32'h5a5a_0100);    // channel 3 command 0x100

        // out of range index leaves its bus slot to a fw write
        rt_in = '{wen: 1'b1, idx: 3'd6, wdata: 32'h0000_dead};
        tick();
        rt_in.wen = 1'b0;
        host_write(1'b0, main_addr(4'h2, `OFF_DAC_CTRL), 32'h0000_0c35);
        read_reg(1'b0, main_addr(4'h2, `OFF_DAC_CTRL));

        read_reg(1'b1, main_addr(4'h3, `OFF_DAC_CTRL));
        read_reg(1'b0, main_addr(4'h0, `OFF_STATUS));
        close_test("rt quadlets");

        // axis 2 sits on channel 3
        adc_sample(2'd2, 16'h0300);
        adc_sample(2'd2, 16'h0300);
        adc_sample(2'd2, 16'h0200);         // exactly twice the command
        adc_sample(2'd2, 16'h0300);
        adc_sample(2'd2, 16'h0300);
        read_reg(1'b0, main_addr(4'h0, `OFF_STATUS));
        adc_sample(2'd2, 16'h0300);
        wait_amp_low(2'd2);
        read_reg(1'b0, main_addr(4'h3, `OFF_ADC_DATA));
        read_reg(1'b0, main_addr(4'h0, `OFF_STATUS));
        host_write(1'b1, main_addr(4'h0, `OFF_STATUS), status_cmd(1'b0, 1'b0, 4'h4, 4'h4));
        read_reg(1'b1, main_addr(4'h0, `OFF_STATUS));
        close_test("safety latch");

        $display("tests run %0d, tests with errors %0d, check errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
// free-running 8 ns clock, reset held low for the first 5 rising edges
`timescale 1ns/10ps

module tb_clock_gen (
    output logic sysclk,
    output logic rst_n
);

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;    // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge sysclk);
        #1 rst_n = 1'b1;    // released clear of the edge
    end

endmodule

/* src/motor_board_top.sv */
// one clock domain only, and adc feedback arrives as parallel words with a ready strobe
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module motor_board_top import motor_pkg::*; (
    input  logic               sysclk,
    input  logic               rst_n,
    input  logic [3:0]         board_id,
    input  reg_wr_t            eth_wr,
    input  reg_wr_t            fw_wr,
    input  rt_wr_t             rt_in,
    input  logic               eth_read_en,
    input  reg_addr_t          eth_raddr,
    input  reg_addr_t          fw_raddr,
    input  cur_vec_t           cur_fb,
    input  logic               cur_ready,
    output logic [`DATA_W-1:0] reg_rdata,
    output logic               pwr_enable,
    output axis_vec_t          amp_enable
);

    // --------------------
    // internal bus
    reg_wr_t            rt_bus;
    reg_wr_t            bus_wr;         // arbitrated write
    reg_addr_t          raddr;          // selected read address
    logic [`DATA_W-1:0] status_rdata;
    logic [`CUR_W-1:0]  dac_rdata;
    logic [`CUR_W-1:0]  fb_rdata;
    cur_vec_t           cur_cmd;
    axis_vec_t          clear_disable;
    axis_vec_t          safety_disable;

    rt_block_writer i_rt (
        .sysclk(sysclk), .rst_n(rst_n),
        .rt_in(rt_in),
        .rt_bus(rt_bus)
    );

    reg_bus_arbiter i_arb (
        .sysclk(sysclk), .rst_n(rst_n),
        .rt_bus(rt_bus), .eth_wr(eth_wr), .fw_wr(fw_wr),
        .eth_read_en(eth_read_en), .eth_raddr(eth_raddr), .fw_raddr(fw_raddr),
        .status_rdata(status_rdata), .dac_rdata(dac_rdata), .fb_rdata(fb_rdata),
        .bus_wr(bus_wr), .raddr(raddr), .reg_rdata(reg_rdata)
    );

    dac_cmd_regs i_dac (
        .sysclk(sysclk), .rst_n(rst_n),
        .bus_wr(bus_wr), .raddr(raddr),
        .dac_rdata(dac_rdata), .cur_cmd(cur_cmd)
    );

    safety_monitor i_safe (
        .sysclk(sysclk), .rst_n(rst_n),
        .cur_fb(cur_fb), .cur_ready(cur_ready), .cur_cmd(cur_cmd),
        .clear_disable(clear_disable), .raddr(raddr),
        .fb_rdata(fb_rdata), .safety_disable(safety_disable)
    );

    board_status_regs i_chan0 (
        .sysclk(sysclk), .rst_n(rst_n),
        .board_id(board_id), .bus_wr(bus_wr), .safety_disable(safety_disable),
        .status_rdata(status_rdata), .clear_disable(clear_disable),
        .pwr_enable(pwr_enable), .amp_enable(amp_enable)
    );

endmodule

/* src/board_status_regs.sv */
// power off forces all amplifier outputs low but keeps the per-axis enable commands
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module board_status_regs import motor_pkg::*; (
    input  logic               sysclk,
    input  logic               rst_n,
    input  logic [3:0]         board_id,       // rotary switch
    input  reg_wr_t            bus_wr,
    input  axis_vec_t          safety_disable,
    output logic [`DATA_W-1:0] status_rdata,
    output axis_vec_t          clear_disable,  // same cycle as the write
    output logic               pwr_enable,
    output axis_vec_t          amp_enable
);

    logic      st_wr;       // status register hit
    logic      pwr_on_cmd;  // masked write of power on
    axis_vec_t amp_mask;
    axis_vec_t amp_val;
    axis_vec_t amp_en_q;    // commanded, before power and safety

    assign st_wr = bus_wr.wen
                && (bus_wr.waddr.space == `ADDR_MAIN)
                && (bus_wr.waddr.rsvd == 4'h0)
                && (bus_wr.waddr.chan == 4'h0)
                && (bus_wr.waddr.offset == `OFF_STATUS);

    assign amp_mask   = bus_wr.wdata[`ST_AMP_MASK];
    assign amp_val    = bus_wr.wdata[`ST_AMP_VAL];
    assign pwr_on_cmd = st_wr && bus_wr.wdata[`ST_PWR_MASK] && bus_wr.wdata[`ST_PWR_VAL];

    // --------------------
    // enable registers
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable <= 1'b0;
            amp_en_q   <= '0;
        end else if (st_wr) begin
            if (bus_wr.wdata[`ST_PWR_MASK])
                pwr_enable <= bus_wr.wdata[`ST_PWR_VAL];
            amp_en_q <= (amp_en_q & ~amp_mask) | (amp_val & amp_mask);  // masked bits only
        end
    end

    // power on clears every axis, an amp on only its own
    assign clear_disable = {`NUM_AXES{pwr_on_cmd}}
                         | ({`NUM_AXES{st_wr}} & amp_mask & amp_val);

    assign amp_enable = amp_en_q & {`NUM_AXES{pwr_enable}} & ~safety_disable;

    // --------------------
    // readback word
    always_comb begin
        status_rdata                 = '0;
        status_rdata[`ST_BOARD_ID]   = board_id;
        status_rdata[`ST_PWR_EN]     = pwr_enable;
        status_rdata[`ST_SAFETY_DIS] = safety_disable;
        status_rdata[`ST_AMP_EN]     = amp_enable;      // effective, not amp_en_q
    end

    a_amp_needs_pwr: assert property (@(posedge sysclk) disable iff (!rst_n)
        !pwr_enable |-> (amp_enable == '0));

    // a power-on write restarts every safety latch on the following edge
    a_pwr_clears: assert property (@(posedge sysclk) disable iff (!rst_n)
        pwr_on_cmd |=> (safety_disable == '0));

endmodule

/* src/safety_monitor.sv */
// feedback and command are compared as unsigned magnitudes and the disables stay set until cleared
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module safety_monitor import motor_pkg::*; (
    input  logic              sysclk,
    input  logic              rst_n,
    input  cur_vec_t          cur_fb,
    input  logic              cur_ready,        // one-cycle adc strobe
    input  cur_vec_t          cur_cmd,
    input  axis_vec_t         clear_disable,
    input  reg_addr_t         raddr,
    output logic [`CUR_W-1:0] fb_rdata,
    output axis_vec_t         safety_disable
);

    cur_vec_t                  fb_q;    // last sampled feedback
    axis_vec_t                 over;
    logic [`SAFETY_CNT_W-1:0]  cnt [`NUM_AXES];
    logic [`AXIS_W-1:0]        rd_sel;

    // --------------------
    // feedback capture, readback only
    always_ff @(posedge sysclk) begin
        if (cur_ready)
            fb_q <= cur_fb;
    end

    assign rd_sel   = `AXIS_W'(raddr.chan - 4'h1);
    assign fb_rdata = fb_q[rd_sel];

    // --------------------
    // per-axis over-current check
    for (genvar a = 0; a < `NUM_AXES; a++) begin : g_axis

        // 17 bits so twice the command cannot wrap
        assign over[a] = {1'b0, cur_fb[a]} > {cur_cmd[a], 1'b0};

        always_ff @(posedge sysclk or negedge rst_n) begin
            if (!rst_n) begin
                cnt[a]            <= '0;
                safety_disable[a] <= 1'b0;
            end else if (clear_disable[a]) begin
                cnt[a]            <= '0;    // clear wins over a sample
                safety_disable[a] <= 1'b0;
            end else if (cur_ready) begin
                if (over[a]) begin
                    if (cnt[a] != `SAFETY_CNT_W'(`SAFETY_COUNT))
                        cnt[a] <= cnt[a] + 1'b1;        // saturate
                    if (cnt[a] == `SAFETY_CNT_W'(`SAFETY_COUNT - 1))
                        safety_disable[a] <= 1'b1;      // sticky
                end else begin
                    cnt[a] <= '0;   // one good sample restarts the run
                end
            end
        end

        // a full run of over-current samples always has its latch set
        a_cnt_latched: assert property (@(posedge sysclk) disable iff (!rst_n)
            (cnt[a] == `SAFETY_CNT_W'(`SAFETY_COUNT)) |-> safety_disable[a]);

        // latch can only rise on a strobe with the axis over current
        a_set_cause: assert property (@(posedge sysclk) disable iff (!rst_n)
            $rose(safety_disable[a]) |-> $past(cur_ready && over[a]));
    end

endmodule

/* src/dac_cmd_regs.sv */
// commands are unsigned and only the low CUR_W bits of a write are kept
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module dac_cmd_regs import motor_pkg::*; (
    input  logic              sysclk,
    input  logic              rst_n,
    input  reg_wr_t           bus_wr,
    input  reg_addr_t         raddr,
    output logic [`CUR_W-1:0] dac_rdata,
    output cur_vec_t          cur_cmd
);

    logic               dac_wr;     // dac offset hit, any channel
    logic [`AXIS_W-1:0] rd_sel;

    assign dac_wr = bus_wr.wen
                 && (bus_wr.waddr.space == `ADDR_MAIN)
                 && (bus_wr.waddr.rsvd == 4'h0)
                 && (bus_wr.waddr.offset == `OFF_DAC_CTRL);

    // channel n drives axis n-1
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else if (dac_wr) begin
            for (int a = 0; a < `NUM_AXES; a++) begin
                if (bus_wr.waddr.chan == 4'(a + 1))
                    cur_cmd[a] <= bus_wr.wdata[`CUR_W-1:0];
            end
        end
    end

    // wraps for channel 0 or >4, the arbiter zeroes those reads
    assign rd_sel    = `AXIS_W'(raddr.chan - 4'h1);
    assign dac_rdata = cur_cmd[rd_sel];

endmodule

/* src/rt_block_writer.sv */
// quadlet indices 5 to 7 are dropped silently and every write lands one clock after the strobe
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module rt_block_writer import motor_pkg::*; (
    input  logic    sysclk,
    input  logic    rst_n,
    input  rt_wr_t  rt_in,
    output reg_wr_t rt_bus
);

    logic [3:0]         chan_sel;
    logic [3:0]         off_sel;
    logic [`ADDR_W-1:0] addr_map;   // index mapped to a bus address
    logic               wen_q;
    logic [`ADDR_W-1:0] addr_q;
    logic [`DATA_W-1:0] data_q;

    // index 0 is the board status, 1-4 the axis dac channels
    assign chan_sel = (rt_in.idx == 3'd0) ? 4'h0 : {1'b0, rt_in.idx};
    assign off_sel  = (rt_in.idx == 3'd0) ? `OFF_STATUS : `OFF_DAC_CTRL;
    assign addr_map = {`ADDR_MAIN, 4'h0, chan_sel, off_sel};

    // strobe, valid indices only
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wen_q <= 1'b0;
        else
            wen_q <= rt_in.wen && (rt_in.idx <= 3'd4);
    end

    // payload held until the next quadlet
    always_ff @(posedge sysclk) begin
        if (rt_in.wen) begin
            addr_q <= addr_map;
            data_q <= rt_in.wdata;
        end
    end

    assign rt_bus.wen   = wen_q;    // single cycle
    assign rt_bus.waddr = reg_addr_t'(addr_q);
    assign rt_bus.wdata = data_q;

endmodule

/* src/reg_bus_arbiter.sv */
// writes have no back-pressure so a lower-priority write that collides is dropped
`timescale 1ns/10ps
`include "motor_cfg_cfg.svh"

module reg_bus_arbiter import motor_pkg::*; (
    input  logic               sysclk,
    input  logic               rst_n,
    input  reg_wr_t            rt_bus,         // highest priority
    input  reg_wr_t            eth_wr,
    input  reg_wr_t            fw_wr,          // lowest priority
    input  logic               eth_read_en,    // 1 -> eth owns the read port
    input  reg_addr_t          eth_raddr,
    input  reg_addr_t          fw_raddr,
    input  logic [`DATA_W-1:0] status_rdata,   // channel 0
    input  logic [`CUR_W-1:0]  dac_rdata,
    input  logic [`CUR_W-1:0]  fb_rdata,
    output reg_wr_t            bus_wr,
    output reg_addr_t          raddr,
    output logic [`DATA_W-1:0] reg_rdata
);

    logic               main_hit;   // main space, reserved clear
    logic               axis_hit;   // channel 1..NUM_AXES
    logic [`DATA_W-1:0] rdata_next;

    // --------------------
    // write select, fixed priority
    always_comb begin
        if (rt_bus.wen) begin
            bus_wr = rt_bus;
        end else if (eth_wr.wen) begin
            bus_wr = eth_wr;
        end else begin
            bus_wr = fw_wr;     // idle bus when fw_wr.wen low
        end
    end

    // --------------------
    // read address and data
    assign raddr    = eth_read_en ? eth_raddr : fw_raddr;
    assign main_hit = (raddr.space == `ADDR_MAIN) && (raddr.rsvd == 4'h0);
    assign axis_hit = (raddr.chan != 4'h0) && (raddr.chan <= 4'(`NUM_AXES));

    always_comb begin
        rdata_next = '0;    // unmapped reads 0
        if (main_hit) begin
            if (raddr.chan == 4'h0) begin
                if (raddr.offset == `OFF_STATUS)
                    rdata_next = status_rdata;
            end else if (axis_hit) begin
                case (raddr.offset)
                    `OFF_ADC_DATA: rdata_next = {{(`DATA_W-`CUR_W){1'b0}}, fb_rdata};
                    `OFF_DAC_CTRL: rdata_next = {{(`DATA_W-`CUR_W){1'b0}}, dac_rdata};
                    default:       rdata_next = '0;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_next;    // one clock behind raddr
    end

    // the three host sides are independent, nothing upstream keeps them apart
    a_one_writer: assert property (@(posedge sysclk) disable iff (!rst_n)
        $onehot0({rt_bus.wen, eth_wr.wen, fw_wr.wen}));

endmodule

/* src/motor_pkg.sv */
// shared bus types for the register bus, address fields are fixed at four bits each
package motor_pkg;

`include "motor_cfg_cfg.svh"

    // register address as seen on the bus
    typedef struct packed {
        logic [3:0] space;      // ADDR_MAIN only
        logic [3:0] rsvd;       // must be zero to decode
        logic [3:0] chan;       // 0 board, 1-4 axes
        logic [3:0] offset;
    } reg_addr_t;

    // one quadlet write, wen is a single-cycle level
    typedef struct packed {
        logic              wen;
        reg_addr_t         waddr;
        logic [`DATA_W-1:0] wdata;
    } reg_wr_t;

    // real-time block quadlet from the host side
    typedef struct packed {
        logic              wen;     // strobe
        logic [2:0]        idx;     // 0 status, 1-4 dac, rest ignored
        logic [`DATA_W-1:0] wdata;
    } rt_wr_t;

    // per-axis vectors, element 0 is axis 1
    typedef logic [`NUM_AXES-1:0][`CUR_W-1:0] cur_vec_t;
    typedef logic [`NUM_AXES-1:0]             axis_vec_t;

endpackage

/* include/motor_cfg_cfg.svh */
// bus widths, address map and status bits assume a single main address space and four axes
`ifndef MOTOR_CFG_CFG_SVH
`define MOTOR_CFG_CFG_SVH

// --------------------
// widths and counts
`define DATA_W          32      // register data word
`define ADDR_W          16      // space, reserved, channel, offset
`define CUR_W           16      // current feedback and command
`define NUM_AXES        4
`define AXIS_W          2       // axis index, channel minus one

// --------------------
// address map
`define ADDR_MAIN       4'h0    // main space, the only one decoded
`define OFF_STATUS      4'h0    // channel 0 only
`define OFF_ADC_DATA    4'h0    // channels 1-4, feedback in low half
`define OFF_DAC_CTRL    4'h1    // channels 1-4, command in low half

// --------------------
// status word, write side
`define ST_PWR_MASK     19      // 1 -> apply power value
`define ST_PWR_VAL      18
`define ST_AMP_MASK     11:8    // per-axis change mask
`define ST_AMP_VAL      3:0     // per-axis enable value

// status word, read side
`define ST_BOARD_ID     27:24
`define ST_PWR_EN       19
`define ST_SAFETY_DIS   11:8
`define ST_AMP_EN       3:0     // effective enables, not the raw command

// over-current samples in a row before the axis is disabled
`define SAFETY_COUNT    3
`define SAFETY_CNT_W    2       // must hold SAFETY_COUNT

`endif
